// File: Makefile
VERILATOR  ?= verilator
TOP        := spmm_tb
RTL_TOP    := spmm_top
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
RUN_ARGS   := +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
logic/spmm_num_pkg.sv
logic/spmm_ctrl_pkg.sv
logic/nz_beat_if.sv
logic/spmm_ctrl.sv
logic/rhs_loader.sv
logic/csr_decoder.sv
logic/seg_reduce_lane.sv
logic/result_stream.sv
logic/spmm_top.sv
dv/clock_gen.sv
dv/spmm_props.sv
dv/spmm_tb.sv

// File: dv/clock_gen.sv
module clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD / 2) clock = ~clock;
        end
    end

    // Released just after an edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

// File: dv/spmm_props.sv
module spmm_props #(
    parameter int N = spmm_num_pkg::DEFAULT_N
) (
    input logic clock,
    input logic reset,
    input logic rhs_ready,
    input logic lhs_ready,
    input logic out_ready,
    input logic rhs_start,
    input logic lhs_start,
    input logic out_start,
    input logic lanes_done,
    input logic streaming
);
    import spmm_ctrl_pkg::*;

    localparam int NB = N / ROWS_PER_BEAT;
    localparam int L  = $clog2(N);

    int failures = 0;

    // Sampled on the falling edge, away from all updates
    a_reset_levels: assert property (@(negedge clock)
        reset |-> rhs_ready && !lhs_ready && !out_ready)
    else begin
        $error("ready levels differ from their reset values");
        failures++;
    end

    // lhs_ready rises the cycle after the last B beat, and only then
    a_lhs_ready_rise: assert property (@(negedge clock) disable iff (reset)
        $rose(lhs_ready) == $past(rhs_ready && rhs_start, NB + 1))
    else begin
        $error("lhs_ready did not rise one cycle after the last rhs beat");
        failures++;
    end

    // Decode, multiply, scan levels, tail select, store
    a_out_ready_rise: assert property (@(negedge clock) disable iff (reset)
        $rose(out_ready) == $past(lhs_ready && lhs_start, L + 5))
    else begin
        $error("out_ready latency after lhs_start is wrong");
        failures++;
    end

    a_rhs_ready_rise: assert property (@(negedge clock) disable iff (reset)
        $rose(rhs_ready) == $past(out_ready && out_start, NB + 1))
    else begin
        $error("rhs_ready did not return one cycle after the last out beat");
        failures++;
    end

    // A refused lhs_start never produces a result matrix
    a_lhs_ignored: assert property (@(negedge clock) disable iff (reset)
        lhs_start && !lhs_ready |-> ##(L + 4) !lanes_done)
    else begin
        $error("lhs_start was taken while lhs_ready was low");
        failures++;
    end

    a_out_ignored: assert property (@(negedge clock) disable iff (reset)
        out_start && !out_ready && !streaming |=> !streaming)
    else begin
        $error("out_start started a stream while out_ready was low");
        failures++;
    end

endmodule

bind spmm_top spmm_props #(.N(N)) i_props (
    .clock      (clock),
    .reset      (reset),
    .rhs_ready  (rhs_ready),
    .lhs_ready  (lhs_ready),
    .out_ready  (out_ready),
    .rhs_start  (rhs_start),
    .lhs_start  (lhs_start),
    .out_start  (out_start),
    .lanes_done (lanes_done),
    .streaming  (streaming)
);

// File: dv/spmm_tb.sv
module spmm_tb;
    import spmm_num_pkg::*;
    import spmm_ctrl_pkg::*;

    localparam int N            = DEFAULT_N;
    localparam int W            = DEFAULT_W;
    localparam int IW           = $clog2(N);
    localparam int PW           = ptr_width(N);
    localparam int NB           = N / ROWS_PER_BEAT;
    localparam int NUM_MATRICES = 6;
    localparam int RUN_LIMIT    = NUM_MATRICES * (N / 2 + IW + 20) * 10;

    logic          clock;
    logic          reset;
    logic          rhs_ready;
    logic          lhs_ready;
    logic          out_ready;
    logic          rhs_start;
    logic          lhs_start;
    logic          out_start;
    logic [W-1:0]  rhs_data [ROWS_PER_BEAT][N];
    logic [PW-1:0] lhs_ptr [N];
    logic [IW-1:0] lhs_col [N];
    logic [W-1:0]  lhs_data [N];
    logic [W-1:0]  out_data [ROWS_PER_BEAT][N];

    // Reference operands and expected product
    logic [W-1:0]  b_mat [N][N];
    logic [W-1:0]  exp_c [N][N];
    logic [W-1:0]  exp_beat [ROWS_PER_BEAT][N];
    logic          beat_on;
    int            beat_num;
    int            check_errors;
    int            tests_passed;
    int            tests_failed;

    clock_gen #(.PERIOD(10), .RESET_CYCLES(4)) i_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    spmm_top #(.N(N), .W(W)) i_dut (
        .clock     (clock),
        .reset     (reset),
        .rhs_ready (rhs_ready),
        .lhs_ready (lhs_ready),
        .out_ready (out_ready),
        .rhs_start (rhs_start),
        .lhs_start (lhs_start),
        .out_start (out_start),
        .rhs_data  (rhs_data),
        .lhs_ptr   (lhs_ptr),
        .lhs_col   (lhs_col),
        .lhs_data  (lhs_data),
        .out_data  (out_data)
    );

    // Expected out beat, zero outside a stream
    always_comb begin
        for (int i = 0; i < ROWS_PER_BEAT; i++) begin
            for (int j = 0; j < N; j++) begin
                exp_beat[i][j] = beat_on ? exp_c[beat_num * ROWS_PER_BEAT + i][j] : '0;
            end
        end
    end

    for (genvar i = 0; i < ROWS_PER_BEAT; i++) begin : g_row
        for (genvar j = 0; j < N; j++) begin : g_col
            a_out_word: assert property (@(negedge clock) disable iff (reset)
                out_data[i][j] == exp_beat[i][j])
            else begin
                $display("CHECK FAILED time %0t out_data[%0d][%0d] expected %0h actual %0h",
                         $time, i, j, exp_beat[i][j], out_data[i][j]);
                check_errors++;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic load_rhs();
        while (!rhs_ready) begin
            next_cycle();
        end
        rhs_start = 1'b1;
        next_cycle();
        rhs_start = 1'b0;
        for (int k = 0; k < NB; k++) begin
            for (int i = 0; i < ROWS_PER_BEAT; i++) begin
                for (int j = 0; j < N; j++) begin
                    rhs_data[i][j] = b_mat[k * ROWS_PER_BEAT + i][j];
                end
            end
            next_cycle();
        end
        rhs_data = '{default: '{default: '0}};
    endtask

    // Permutation-like A, or rows of 0..3 nonzeros with some forced empty
    task automatic make_lhs(input bit one_per_row);
        int total;
        int count;
        total = 0;
        for (int i = 0; i < N; i++) begin
            lhs_data[i] = W'($urandom);
            lhs_col[i]  = IW'($urandom_range(N - 1, 0));
        end
        for (int r = 0; r < N; r++) begin
            if (one_per_row) begin
                count = 1;
                lhs_col[r] = IW'((r * 5 + 3) % N);
            end else begin
                count = (r % 5 == 2) ? 0 : int'($urandom_range(3, 0));
            end
            if (count > N - total) begin
                count = N - total;
            end
            total += count;
            lhs_ptr[r] = PW'(total);
        end
    endtask

    // Row r of C sums value times row col of B over the row's nonzeros
    function automatic void compute_expected();
        int first;
        logic [W-1:0] acc;
        for (int r = 0; r < N; r++) begin
            first = (r == 0) ? 0 : int'(lhs_ptr[r-1]);
            for (int j = 0; j < N; j++) begin
                acc = '0;
                for (int i = first; i < int'(lhs_ptr[r]); i++) begin
                    acc = acc + W'(lhs_data[i] * b_mat[lhs_col[i]][j]);
                end
                exp_c[r][j] = acc;
            end
        end
    endfunction

    task automatic send_lhs();
        while (!lhs_ready) begin
            next_cycle();
        end
        lhs_start = 1'b1;
        next_cycle();
        lhs_start = 1'b0;
    endtask

    task automatic stream_out();
        while (!out_ready) begin
            next_cycle();
        end
        out_start = 1'b1;
        next_cycle();
        out_start = 1'b0;
        beat_num = 0;
        beat_on  = 1'b1;
        for (int k = 0; k < NB; k++) begin
            next_cycle();
            if (k < NB - 1) begin
                beat_num = k + 1;
            end else begin
                beat_on = 1'b0;
            end
        end
        next_cycle();
    endtask

    task automatic pulse_starts();
        lhs_start = 1'b1;
        out_start = 1'b1;
        next_cycle();
        lhs_start = 1'b0;
        out_start = 1'b0;
    endtask

    task automatic run_product(input string name, input bit one_per_row, input bit poke);
        int errors_before;
        errors_before = check_errors + i_dut.i_props.failures;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                b_mat[r][c] = W'($urandom);
            end
        end
        // Starts outside their ready window, once in IDLE and once in PROCESS
        if (poke) begin
            pulse_starts();
        end
        load_rhs();
        make_lhs(one_per_row);
        compute_expected();
        send_lhs();
        if (poke) begin
            pulse_starts();
        end
        stream_out();
        if (check_errors + i_dut.i_props.failures == errors_before) begin
            tests_passed++;
            $display("test %s: PASS", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL", name);
        end
    endtask

    initial begin
        void'($urandom(32'hc6c2_4c9e));
        rhs_start    = 1'b0;
        lhs_start    = 1'b0;
        out_start    = 1'b0;
        rhs_data     = '{default: '{default: '0}};
        lhs_ptr      = '{default: '0};
        lhs_col      = '{default: '0};
        lhs_data     = '{default: '0};
        beat_on      = 1'b0;
        beat_num     = 0;
        check_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        @(negedge reset);
        next_cycle();
        run_product("one_per_row", 1'b1, 1'b0);
        run_product("random_rows", 1'b0, 1'b0);
        run_product("ignored_starts", 1'b0, 1'b1);
        for (int m = 0; m < 3; m++) begin
            run_product($sformatf("back_to_back_%0d", m), 1'b0, 1'b0);
        end
        $display("tests run %0d, passed %0d, failed %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed);
        if (tests_failed == 0 && check_errors + i_dut.i_props.failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(RUN_LIMIT);
        $display("watchdog expired after %0d time units before the run finished", RUN_LIMIT);
        $display("tests failed");
        $finish;
    end

endmodule

// File: logic/csr_decoder.sv
module csr_decoder #(
    parameter int N = spmm_num_pkg::DEFAULT_N,
    parameter int W = spmm_num_pkg::DEFAULT_W
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  lhs_take,
    input  logic [spmm_num_pkg::ptr_width(N)-1:0] lhs_ptr [N],
    input  logic [$clog2(N)-1:0]                  lhs_col [N],
    input  logic [W-1:0]                          lhs_data [N],
    nz_beat_if.source                             nz
);
    import spmm_num_pkg::*;

    localparam int IW = $clog2(N);
    localparam int PW = ptr_width(N);

    logic [PW-1:0] row_start [N];
    logic [N-1:0]  head_d;
    logic [N-1:0]  empty_d;
    logic [IW-1:0] tail_d [N];

    // Row r starts where row r-1 ended
    always_comb begin
        row_start[0] = '0;
        for (int r = 1; r < N; r++) begin
            row_start[r] = lhs_ptr[r-1];
        end
    end

    always_comb begin
        head_d = '0;
        for (int r = 0; r < N; r++) begin
            empty_d[r] = (lhs_ptr[r] == row_start[r]);
            tail_d[r]  = IW'(lhs_ptr[r] - 1'b1);
            // Empty rows share their start with the next row, harmless
            if (row_start[r] < PW'(N)) begin
                head_d[row_start[r][IW-1:0]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            nz.valid <= 1'b0;
        end else begin
            nz.valid <= lhs_take;
        end
    end

    always_ff @(posedge clock) begin
        if (lhs_take) begin
            for (int i = 0; i < N; i++) begin
                nz.value[i]    <= lhs_data[i];
                nz.col[i]      <= lhs_col[i];
                nz.row_tail[i] <= tail_d[i];
            end
            nz.seg_head  <= head_d;
            nz.row_empty <= empty_d;
        end
    end

endmodule

// File: logic/nz_beat_if.sv
interface nz_beat_if #(
    parameter int N = spmm_num_pkg::DEFAULT_N,
    parameter int W = spmm_num_pkg::DEFAULT_W
);
    localparam int IW = $clog2(N);

    // High for the single cycle a decoded beat of A is present
    logic          valid;

    // Per nonzero slot
    logic [W-1:0]  value [N];
    logic [IW-1:0] col [N];
    logic [N-1:0]  seg_head;

    // Per row of A
    logic [IW-1:0] row_tail [N];
    logic [N-1:0]  row_empty;

    modport source (
        output valid, value, col, seg_head, row_tail, row_empty
    );

    modport lane (
        input valid, value, col, seg_head, row_tail, row_empty
    );

endinterface

// File: logic/result_stream.sv
module result_stream #(
    parameter int N = spmm_num_pkg::DEFAULT_N,
    parameter int W = spmm_num_pkg::DEFAULT_W,
    localparam int BW = spmm_ctrl_pkg::beat_width(N)
) (
    input  logic          clock,
    input  logic          reset,
    input  logic [N-1:0]  c_valid,
    input  logic [W-1:0]  c_columns [N][N],
    input  logic          streaming,
    input  logic [BW-1:0] beat_idx,
    output logic          lanes_done,
    output logic [W-1:0]  out_data [spmm_ctrl_pkg::ROWS_PER_BEAT][N]
);
    import spmm_ctrl_pkg::*;

    logic [W-1:0] c_rows [N][N];
    logic         all_valid;

    // Lanes run in lockstep, so all columns land together
    assign all_valid = &c_valid;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lanes_done <= 1'b0;
        end else begin
            lanes_done <= all_valid;
        end
    end

    // Back to row-major order for streaming
    always_ff @(posedge clock) begin
        if (all_valid) begin
            for (int r = 0; r < N; r++) begin
                for (int j = 0; j < N; j++) begin
                    c_rows[r][j] <= c_columns[j][r];
                end
            end
        end
    end

    // Zero outside a stream
    always_comb begin
        int row;
        for (int i = 0; i < ROWS_PER_BEAT; i++) begin
            row = int'(beat_idx) * ROWS_PER_BEAT + i;
            for (int j = 0; j < N; j++) begin
                out_data[i][j] = streaming ? c_rows[row][j] : '0;
            end
        end
    end

endmodule

// File: logic/rhs_loader.sv
module rhs_loader #(
    parameter int N = spmm_num_pkg::DEFAULT_N,
    parameter int W = spmm_num_pkg::DEFAULT_W,
    localparam int BW = spmm_ctrl_pkg::beat_width(N)
) (
    input  logic          clock,
    input  logic          reset,
    input  logic          loading,
    input  logic [BW-1:0] beat_idx,
    input  logic [W-1:0]  rhs_data [spmm_ctrl_pkg::ROWS_PER_BEAT][N],
    output logic [W-1:0]  b_columns [N][N]
);
    import spmm_ctrl_pkg::*;

    logic          wr_en_q;
    logic [BW-1:0] wr_blk_q;
    logic [W-1:0]  wr_rows_q [ROWS_PER_BEAT][N];

    // Input beat is registered first, written one cycle later
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= loading;
        end
    end

    always_ff @(posedge clock) begin
        if (loading) begin
            wr_blk_q  <= beat_idx;
            wr_rows_q <= rhs_data;
        end
    end

    // Stored transposed, b_columns[j] is column j of B
    always_ff @(posedge clock) begin
        int row;
        if (wr_en_q) begin
            for (int i = 0; i < ROWS_PER_BEAT; i++) begin
                row = int'(wr_blk_q) * ROWS_PER_BEAT + i;
                for (int j = 0; j < N; j++) begin
                    b_columns[j][row] <= wr_rows_q[i][j];
                end
            end
        end
    end

endmodule

// File: logic/seg_reduce_lane.sv
module seg_reduce_lane #(
    parameter int N = spmm_num_pkg::DEFAULT_N,
    parameter int W = spmm_num_pkg::DEFAULT_W
) (
    input  logic         clock,
    input  logic         reset,
    input  logic [W-1:0] b_column [N],
    nz_beat_if.lane      nz,
    output logic [W-1:0] c_column [N],
    output logic         c_valid
);
    localparam int IW = $clog2(N);
    localparam int L  = $clog2(N);

    // Stage 0 is the multiply, stages 1..L the scan levels
    logic [W-1:0]  sum_q   [L+1][N];
    logic [N-1:0]  head_q  [L+1];
    logic [IW-1:0] tail_q  [L+1][N];
    logic [N-1:0]  empty_q [L+1];
    logic [L:0]    vld_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            vld_q   <= '0;
            c_valid <= 1'b0;
        end else begin
            vld_q   <= {vld_q[L-1:0], nz.valid};
            c_valid <= vld_q[L];
        end
    end

    // Product keeps the low W bits
    always_ff @(posedge clock) begin
        for (int i = 0; i < N; i++) begin
            sum_q[0][i]  <= nz.value[i] * b_column[nz.col[i]];
            tail_q[0][i] <= nz.row_tail[i];
        end
        head_q[0]  <= nz.seg_head;
        empty_q[0] <= nz.row_empty;
    end

    // Segmented inclusive scan, one doubling step per level.
    // A set flag means the window already reaches its row start.
    for (genvar l = 0; l < L; l++) begin : g_level
        localparam int D = 1 << l;

        always_ff @(posedge clock) begin
            for (int i = 0; i < D; i++) begin
                sum_q[l+1][i] <= sum_q[l][i];
            end
            for (int i = D; i < N; i++) begin
                if (head_q[l][i]) begin
                    sum_q[l+1][i] <= sum_q[l][i];
                end else begin
                    sum_q[l+1][i] <= sum_q[l][i] + sum_q[l][i-D];
                end
            end
            head_q[l+1]  <= head_q[l] | (head_q[l] << D);
            tail_q[l+1]  <= tail_q[l];
            empty_q[l+1] <= empty_q[l];
        end
    end

    // Row total sits at the row's last nonzero
    always_ff @(posedge clock) begin
        for (int r = 0; r < N; r++) begin
            if (empty_q[L][r]) begin
                c_column[r] <= '0;
            end else begin
                c_column[r] <= sum_q[L][tail_q[L][r]];
            end
        end
    end

endmodule

// File: logic/spmm_ctrl.sv
module spmm_ctrl #(
    parameter int N = spmm_num_pkg::DEFAULT_N,
    parameter int W = spmm_num_pkg::DEFAULT_W,
    localparam int BW = spmm_ctrl_pkg::beat_width(N)
) (
    input  logic          clock,
    input  logic          reset,
    input  logic          rhs_start,
    input  logic          lhs_start,
    input  logic          out_start,
    input  logic          lanes_done,
    output logic          rhs_ready,
    output logic          lhs_ready,
    output logic          out_ready,
    output logic          loading,
    output logic          lhs_take,
    output logic          streaming,
    output logic [BW-1:0] beat_idx
);
    import spmm_ctrl_pkg::*;

    localparam int NBEATS = N / ROWS_PER_BEAT;

    spmm_state_t state;
    logic        last_beat;

    if (N < ROWS_PER_BEAT || (N & (N - 1)) != 0 || W < 1) begin : g_param_check
        $error("spmm_ctrl needs N a power of two of at least 4 and W of at least 1");
    end

    // Ready levels follow the phase directly
    assign rhs_ready = (state == IDLE);
    assign lhs_ready = (state == WAIT_LHS);
    assign out_ready = (state == STREAM_OUT) && !streaming;

    assign loading   = (state == LOAD_RHS);
    assign lhs_take  = lhs_ready && lhs_start;
    assign last_beat = (beat_idx == BW'(NBEATS - 1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            streaming <= 1'b0;
            beat_idx  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (rhs_start) begin
                        state    <= LOAD_RHS;
                        beat_idx <= '0;
                    end
                end
                LOAD_RHS: begin
                    if (last_beat) begin
                        state    <= WAIT_LHS;
                        beat_idx <= '0;
                    end else begin
                        beat_idx <= beat_idx + 1'b1;
                    end
                end
                WAIT_LHS: begin
                    if (lhs_take) begin
                        state <= PROCESS;
                    end
                end
                PROCESS: begin
                    // Result matrix is stored, offer it
                    if (lanes_done) begin
                        state <= STREAM_OUT;
                    end
                end
                STREAM_OUT: begin
                    if (!streaming) begin
                        if (out_start) begin
                            streaming <= 1'b1;
                            beat_idx  <= '0;
                        end
                    end else if (last_beat) begin
                        streaming <= 1'b0;
                        beat_idx  <= '0;
                        state     <= IDLE;
                    end else begin
                        beat_idx <= beat_idx + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/spmm_ctrl_pkg.sv
package spmm_ctrl_pkg;

    // Rows of B or C moved per transfer beat
    localparam int ROWS_PER_BEAT = 4;

    // Phase sequence, one matrix product per pass
    typedef enum logic [2:0] {
        IDLE,
        LOAD_RHS,
        WAIT_LHS,
        PROCESS,
        STREAM_OUT
    } spmm_state_t;

    // Width of the beat index for an N-row matrix
    function automatic int beat_width(input int n);
        // Single-beat transfers still get a one-bit index
        if (n > ROWS_PER_BEAT) begin
            return $clog2(n / ROWS_PER_BEAT);
        end
        return 1;
    endfunction

endpackage

// File: logic/spmm_num_pkg.sv
package spmm_num_pkg;

    // Lane count and size of both square matrices
    // Must be a power of two and at least 4
    localparam int DEFAULT_N = 16;

    // Data width, all arithmetic wraps at this width
    localparam int DEFAULT_W = 8;

    // Row-end pointers count nonzeros up to N inclusive,
    // so they need one bit more than a column index
    function automatic int ptr_width(input int n);
        return $clog2(n) + 1;
    endfunction

endpackage

// File: logic/spmm_top.sv
module spmm_top #(
    parameter int N = spmm_num_pkg::DEFAULT_N,
    parameter int W = spmm_num_pkg::DEFAULT_W
) (
    input  logic                                  clock,
    input  logic                                  reset,
    output logic                                  rhs_ready,
    output logic                                  lhs_ready,
    output logic                                  out_ready,
    input  logic                                  rhs_start,
    input  logic                                  lhs_start,
    input  logic                                  out_start,
    input  logic [W-1:0]                          rhs_data [spmm_ctrl_pkg::ROWS_PER_BEAT][N],
    input  logic [spmm_num_pkg::ptr_width(N)-1:0] lhs_ptr [N],
    input  logic [$clog2(N)-1:0]                  lhs_col [N],
    input  logic [W-1:0]                          lhs_data [N],
    output logic [W-1:0]                          out_data [spmm_ctrl_pkg::ROWS_PER_BEAT][N]
);
    import spmm_ctrl_pkg::*;

    localparam int BW = beat_width(N);

    logic          loading;
    logic          lhs_take;
    logic          streaming;
    logic          lanes_done;
    logic [BW-1:0] beat_idx;
    logic [W-1:0]  b_columns [N][N];
    logic [W-1:0]  c_columns [N][N];
    logic [N-1:0]  c_valid;

    nz_beat_if #(.N(N), .W(W)) nz_beat ();

    spmm_ctrl #(.N(N), .W(W)) i_ctrl (
        .clock      (clock),
        .reset      (reset),
        .rhs_start  (rhs_start),
        .lhs_start  (lhs_start),
        .out_start  (out_start),
        .lanes_done (lanes_done),
        .rhs_ready  (rhs_ready),
        .lhs_ready  (lhs_ready),
        .out_ready  (out_ready),
        .loading    (loading),
        .lhs_take   (lhs_take),
        .streaming  (streaming),
        .beat_idx   (beat_idx)
    );

    rhs_loader #(.N(N), .W(W)) i_rhs_loader (
        .clock     (clock),
        .reset     (reset),
        .loading   (loading),
        .beat_idx  (beat_idx),
        .rhs_data  (rhs_data),
        .b_columns (b_columns)
    );

    csr_decoder #(.N(N), .W(W)) i_csr_decoder (
        .clock    (clock),
        .reset    (reset),
        .lhs_take (lhs_take),
        .lhs_ptr  (lhs_ptr),
        .lhs_col  (lhs_col),
        .lhs_data (lhs_data),
        .nz       (nz_beat)
    );

    // One lane per column of B and C
    for (genvar j = 0; j < N; j++) begin : g_lane
        seg_reduce_lane #(.N(N), .W(W)) i_lane (
            .clock    (clock),
            .reset    (reset),
            .b_column (b_columns[j]),
            .nz       (nz_beat),
            .c_column (c_columns[j]),
            .c_valid  (c_valid[j])
        );
    end

    result_stream #(.N(N), .W(W)) i_result_stream (
        .clock      (clock),
        .reset      (reset),
        .c_valid    (c_valid),
        .c_columns  (c_columns),
        .streaming  (streaming),
        .beat_idx   (beat_idx),
        .lanes_done (lanes_done),
        .out_data   (out_data)
    );

endmodule
